// ==== design/acc_pkg.sv ====
/*
 * Shared types, widths and the register map of the dot-product accelerator.
 * Memory is word addressed with 32-bit words, vector elements sit in the low half.
 * Register offsets are decoded from the low address bits only.
 */

package acc_pkg;

  localparam int unsigned DataWidth   = 32;
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned LenWidth    = 16;
  localparam int unsigned ElemWidth   = 16;  // Signed vector element
  localparam int unsigned StrbWidth   = DataWidth / 8;
  localparam int unsigned RegOffWidth = 5;

  // AXI4-Lite response codes
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  // Register map
  localparam logic [RegOffWidth-1:0] RegCtrl    = 5'h00;  // Bit 0 start, write only
  localparam logic [RegOffWidth-1:0] RegStatus  = 5'h04;  // Bit 0 busy, bit 1 done (W1C)
  localparam logic [RegOffWidth-1:0] RegAAddr   = 5'h08;
  localparam logic [RegOffWidth-1:0] RegBAddr   = 5'h0C;
  localparam logic [RegOffWidth-1:0] RegDstAddr = 5'h10;
  localparam logic [RegOffWidth-1:0] RegLen     = 5'h14;
  localparam logic [RegOffWidth-1:0] RegResult  = 5'h18;  // Read only

  // Master-driven AXI4-Lite fields
  typedef struct packed {
    logic [AddrWidth-1:0] aw_addr;
    logic                 aw_valid;
    logic [DataWidth-1:0] w_data;
    logic [StrbWidth-1:0] w_strb;
    logic                 w_valid;
    logic                 b_ready;
    logic [AddrWidth-1:0] ar_addr;
    logic                 ar_valid;
    logic                 r_ready;
  } axil_req_t;

  typedef struct packed {
    logic                 aw_ready;
    logic                 w_ready;
    logic [1:0]           b_resp;
    logic                 b_valid;
    logic                 ar_ready;
    logic [DataWidth-1:0] r_data;
    logic [1:0]           r_resp;
    logic                 r_valid;
  } axil_rsp_t;

  // Cluster memory request/grant port
  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                 gnt;
    logic                 rvalid;  // One cycle after the read grant
    logic [DataWidth-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic [AddrWidth-1:0] a_addr;
    logic [AddrWidth-1:0] b_addr;
    logic [AddrWidth-1:0] dst_addr;
    logic [LenWidth-1:0]  len;
  } acc_cfg_t;

  typedef struct packed {
    logic signed [ElemWidth-1:0] a;
    logic signed [ElemWidth-1:0] b;
    logic                        last;  // Final pair of the job
  } mac_op_t;

endpackage

// ==== design/acc_regfile.sv ====
/*
 * AXI4-Lite slave with the accelerator registers. One write and one read in flight.
 * Only the low address bits are decoded, so the map aliases across the address space.
 * Config writes and starts are dropped while the job runs; the response is still OKAY.
 */

`timescale 1ns/10ps

module acc_regfile (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          en_i,
  input  acc_pkg::axil_req_t            axil_req_i,
  output acc_pkg::axil_rsp_t            axil_rsp_o,
  input  logic                          busy_i,
  input  logic                          done_i,
  input  logic [acc_pkg::DataWidth-1:0] sum_i,
  output logic                          start_o,
  output acc_pkg::acc_cfg_t             cfg_o,
  output logic                          irq_o
);
  import acc_pkg::*;

  logic [RegOffWidth-1:0] wr_off;
  logic [RegOffWidth-1:0] rd_off;
  logic                   wr_accept;
  logic                   rd_accept;
  logic                   b_hs;
  logic                   wr_mapped;
  logic                   rd_mapped;
  logic                   done_clr;
  logic                   b_valid_q;
  logic                   r_valid_q;
  logic [1:0]             b_resp_q;
  logic [1:0]             r_resp_q;
  logic [DataWidth-1:0]   r_data_q;
  logic [DataWidth-1:0]   rd_data;
  logic                   start_pend_q;
  logic                   done_q;
  logic [DataWidth-1:0]   result_q;
  acc_cfg_t               cfg_q;

  // Byte-wise update under the write strobes
  function automatic logic [DataWidth-1:0] merge_strb(input logic [DataWidth-1:0] old_v,
                                                      input logic [DataWidth-1:0] new_v,
                                                      input logic [StrbWidth-1:0] strb);
    logic [DataWidth-1:0] res;
    res = old_v;
    for (int i = 0; i < StrbWidth; i++) begin
      if (strb[i]) res[8*i +: 8] = new_v[8*i +: 8];
    end
    return res;
  endfunction

  function automatic logic is_mapped(input logic [RegOffWidth-1:0] off);
    logic hit;
    case (off)
      RegCtrl, RegStatus, RegAAddr, RegBAddr, RegDstAddr, RegLen, RegResult: hit = 1'b1;
      default: hit = 1'b0;
    endcase
    return hit;
  endfunction

  assign wr_off    = axil_req_i.aw_addr[RegOffWidth-1:0];
  assign rd_off    = axil_req_i.ar_addr[RegOffWidth-1:0];
  assign wr_mapped = is_mapped(wr_off);
  assign rd_mapped = is_mapped(rd_off);

  // AW and W taken together, never with a B still pending
  assign wr_accept = en_i & axil_req_i.aw_valid & axil_req_i.w_valid & ~b_valid_q;
  assign rd_accept = en_i & axil_req_i.ar_valid & ~r_valid_q;
  assign b_hs      = en_i & b_valid_q & axil_req_i.b_ready;
  assign done_clr  = wr_accept & (wr_off == RegStatus) & axil_req_i.w_strb[0]
                   & axil_req_i.w_data[1];

  // Start fires with the B handshake of the start write
  assign start_o = b_hs & start_pend_q;

  always_comb begin
    axil_rsp_o          = '0;
    axil_rsp_o.aw_ready = wr_accept;
    axil_rsp_o.w_ready  = wr_accept;
    axil_rsp_o.b_valid  = b_valid_q;
    axil_rsp_o.b_resp   = b_resp_q;
    axil_rsp_o.ar_ready = en_i & ~r_valid_q;
    axil_rsp_o.r_valid  = r_valid_q;
    axil_rsp_o.r_data   = r_data_q;
    axil_rsp_o.r_resp   = r_resp_q;
  end

  always_comb begin
    case (rd_off)
      RegStatus:  rd_data = {{(DataWidth-2){1'b0}}, done_q, busy_i};
      RegAAddr:   rd_data = cfg_q.a_addr;
      RegBAddr:   rd_data = cfg_q.b_addr;
      RegDstAddr: rd_data = cfg_q.dst_addr;
      RegLen:     rd_data = {{(DataWidth-LenWidth){1'b0}}, cfg_q.len};
      RegResult:  rd_data = result_q;
      default:    rd_data = '0;  // Ctrl and unmapped
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_valid_q    <= 1'b0;
      r_valid_q    <= 1'b0;
      b_resp_q     <= RespOkay;
      r_resp_q     <= RespOkay;
      start_pend_q <= 1'b0;
      done_q       <= 1'b0;
      result_q     <= '0;
      cfg_q        <= '0;
    end else if (en_i) begin
      if (wr_accept) begin
        b_valid_q <= 1'b1;
        b_resp_q  <= wr_mapped ? RespOkay : RespSlvErr;
      end else if (b_hs) begin
        b_valid_q <= 1'b0;
      end

      if (rd_accept) begin
        r_valid_q <= 1'b1;
        r_resp_q  <= rd_mapped ? RespOkay : RespSlvErr;
      end else if (r_valid_q && axil_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end

      if (b_hs) start_pend_q <= 1'b0;

      if (wr_accept && !busy_i) begin
        case (wr_off)
          RegCtrl: begin
            if (axil_req_i.w_strb[0] && axil_req_i.w_data[0]) start_pend_q <= 1'b1;
          end
          RegAAddr:   cfg_q.a_addr   <= merge_strb(cfg_q.a_addr, axil_req_i.w_data,
                                                   axil_req_i.w_strb);
          RegBAddr:   cfg_q.b_addr   <= merge_strb(cfg_q.b_addr, axil_req_i.w_data,
                                                   axil_req_i.w_strb);
          RegDstAddr: cfg_q.dst_addr <= merge_strb(cfg_q.dst_addr, axil_req_i.w_data,
                                                   axil_req_i.w_strb);
          RegLen: begin
            cfg_q.len <= LenWidth'(merge_strb({{(DataWidth-LenWidth){1'b0}}, cfg_q.len},
                                              axil_req_i.w_data, axil_req_i.w_strb));
          end
          default: ;
        endcase
      end

      // A finishing job wins over a same-cycle clear
      if (done_i) begin
        done_q   <= 1'b1;
        result_q <= sum_i;
      end else if (done_clr) begin
        done_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) r_data_q <= rd_data;
  end

  assign cfg_o = cfg_q;
  assign irq_o = done_q;

  a_b_after_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(b_valid_q) |-> $past(wr_accept))
    else $error("B valid without an accepted write");

  a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_o |-> !busy_i)
    else $error("start issued while the job is running");

endmodule

// ==== design/acc_streamer.sv ====
/*
 * Memory master of the dot product. One read outstanding, A[i] then B[i] per element.
 * A read response landing while frozen is kept and consumed once enabled again.
 * Length zero skips the reads and writes a zero sum.
 */

`timescale 1ns/10ps

module acc_streamer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          en_i,
  input  logic                          start_i,
  input  acc_pkg::acc_cfg_t             cfg_i,
  output acc_pkg::mem_req_t             mem_req_o,
  input  acc_pkg::mem_rsp_t             mem_rsp_i,
  output logic                          op_valid_o,
  output acc_pkg::mac_op_t              op_o,
  input  logic                          acc_valid_i,
  input  logic [acc_pkg::DataWidth-1:0] acc_i,
  output logic                          busy_o,
  output logic                          done_o,
  output logic [acc_pkg::DataWidth-1:0] sum_o
);
  import acc_pkg::*;

  typedef enum logic [2:0] {
    StIdle,
    StReadA,
    StReadB,
    StWaitSum,
    StWrite
  } state_e;

  state_e               state_q;
  logic [LenWidth-1:0]  idx_q;
  logic                 rd_wait_q;    // Read granted, data not yet back
  logic                 rsp_valid_q;  // Read data held for the FSM
  logic [ElemWidth-1:0] rsp_data_q;
  logic [ElemWidth-1:0] a_q;
  logic [DataWidth-1:0] sum_q;
  logic [AddrWidth-1:0] elem_off;
  logic                 rd_issue;
  logic                 is_last;

  assign elem_off = {{(AddrWidth-LenWidth-2){1'b0}}, idx_q, 2'b00};
  assign rd_issue = (state_q == StReadA || state_q == StReadB) & ~rd_wait_q & ~rsp_valid_q;
  assign is_last  = (idx_q == LenWidth'(cfg_i.len - 1'b1));

  always_comb begin
    mem_req_o.req   = en_i & (rd_issue | (state_q == StWrite));  // Withdrawn while frozen
    mem_req_o.we    = (state_q == StWrite);
    mem_req_o.wdata = sum_q;
    case (state_q)
      StWrite: mem_req_o.addr = cfg_i.dst_addr;
      StReadB: mem_req_o.addr = cfg_i.b_addr + elem_off;
      default: mem_req_o.addr = cfg_i.a_addr + elem_off;
    endcase
  end

  // Pair goes out as soon as B is in hand
  assign op_valid_o = en_i & (state_q == StReadB) & rsp_valid_q;
  assign op_o.a     = a_q;
  assign op_o.b     = rsp_data_q;
  assign op_o.last  = is_last;

  assign done_o = en_i & (state_q == StWrite) & mem_rsp_i.gnt;
  assign busy_o = (state_q != StIdle);
  assign sum_o  = sum_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= StIdle;
      idx_q       <= '0;
      rd_wait_q   <= 1'b0;
      rsp_valid_q <= 1'b0;
      sum_q       <= '0;
    end else begin
      // The memory returns data one cycle after grant, enabled or not
      if (rd_wait_q && mem_rsp_i.rvalid) begin
        rd_wait_q   <= 1'b0;
        rsp_valid_q <= 1'b1;
      end
      if (en_i) begin
        case (state_q)
          StIdle: begin
            if (start_i) begin
              idx_q   <= '0;
              sum_q   <= '0;
              state_q <= (cfg_i.len == '0) ? StWrite : StReadA;
            end
          end
          StReadA, StReadB: begin
            if (rd_issue && mem_rsp_i.gnt) rd_wait_q <= 1'b1;
            if (rsp_valid_q) begin
              rsp_valid_q <= 1'b0;
              if (state_q == StReadA) begin
                state_q <= StReadB;
              end else begin
                idx_q   <= idx_q + 1'b1;
                state_q <= is_last ? StWaitSum : StReadA;
              end
            end
          end
          StWaitSum: begin
            if (acc_valid_i) begin
              sum_q   <= acc_i;
              state_q <= StWrite;
            end
          end
          StWrite: begin
            if (mem_rsp_i.gnt) state_q <= StIdle;
          end
          default: state_q <= StIdle;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_wait_q && mem_rsp_i.rvalid) rsp_data_q <= mem_rsp_i.rdata[ElemWidth-1:0];
    if (en_i && state_q == StReadA && rsp_valid_q) a_q <= rsp_data_q;
  end

  // An ungranted request returns unchanged on the next enabled cycle
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o.req && !mem_rsp_i.gnt) ##1 en_i |-> mem_req_o.req && $stable(mem_req_o))
    else $error("memory request changed before its grant");

endmodule

// ==== design/acc_mac_engine.sv ====
/*
 * Pipelined signed 16x16 multiply-accumulate, MacStages from 1 to 4.
 * The sum wraps modulo 2^32. Always accepts, at most one op per cycle.
 */

`timescale 1ns/10ps

module acc_mac_engine #(
  parameter int unsigned MacStages = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          en_i,
  input  logic                          clear_i,
  input  logic                          op_valid_i,
  input  acc_pkg::mac_op_t              op_i,
  output logic                          acc_valid_o,
  output logic [acc_pkg::DataWidth-1:0] acc_o
);
  import acc_pkg::*;

  logic [MacStages-1:0]        vld_q;
  logic [MacStages-1:0]        last_q;
  logic signed [DataWidth-1:0] prod_q [MacStages];
  logic signed [DataWidth-1:0] prod_d;
  logic [DataWidth-1:0]        acc_q;
  logic [DataWidth-1:0]        acc_sum;

  assign prod_d = $signed(op_i.a) * $signed(op_i.b);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q  <= '0;
      last_q <= '0;
    end else if (en_i) begin
      vld_q[0]  <= op_valid_i;
      last_q[0] <= op_valid_i & op_i.last;
      for (int unsigned i = 1; i < MacStages; i++) begin
        vld_q[i]  <= vld_q[i-1];
        last_q[i] <= last_q[i-1];
      end
    end
  end

  // Product shift chain
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      prod_q[0] <= prod_d;
      for (int unsigned i = 1; i < MacStages; i++) begin
        prod_q[i] <= prod_q[i-1];
      end
    end
  end

  assign acc_sum = acc_q + DataWidth'(prod_q[MacStages-1]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (en_i) begin
      if (clear_i) begin
        acc_q <= '0;  // New job
      end else if (vld_q[MacStages-1]) begin
        acc_q <= acc_sum;
      end
    end
  end

  // Full sum shown in the cycle the last product is added
  assign acc_valid_o = en_i & vld_q[MacStages-1] & last_q[MacStages-1];
  assign acc_o       = acc_sum;

endmodule

// ==== design/acc_complex.sv ====
/*
 * Dot-product accelerator complex with AXI4-Lite registers, memory streamer and MAC engine.
 * enable_i is registered once and freezes all accelerator state while low.
 */

`timescale 1ns/10ps

module acc_complex #(
  parameter int unsigned MacStages = 2  // 1 to 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               enable_i,
  input  acc_pkg::axil_req_t axil_req_i,
  output acc_pkg::axil_rsp_t axil_rsp_o,
  output acc_pkg::mem_req_t  mem_req_o,
  input  acc_pkg::mem_rsp_t  mem_rsp_i,
  output logic               irq_o,
  output logic               busy_o
);
  import acc_pkg::*;

  logic                 en_q;  // Shared enable for all children
  logic                 start;
  logic                 busy;
  logic                 done;
  logic [DataWidth-1:0] sum;
  logic                 op_valid;
  logic                 acc_valid;
  logic [DataWidth-1:0] acc;
  acc_cfg_t             cfg;
  mac_op_t              op;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) en_q <= 1'b0;
    else         en_q <= enable_i;
  end

  acc_regfile u_regfile (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .en_i       ( en_q       ),
    .axil_req_i ( axil_req_i ),
    .axil_rsp_o ( axil_rsp_o ),
    .busy_i     ( busy       ),
    .done_i     ( done       ),
    .sum_i      ( sum        ),
    .start_o    ( start      ),
    .cfg_o      ( cfg        ),
    .irq_o      ( irq_o      )
  );

  acc_streamer u_streamer (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .en_i        ( en_q      ),
    .start_i     ( start     ),
    .cfg_i       ( cfg       ),
    .mem_req_o   ( mem_req_o ),
    .mem_rsp_i   ( mem_rsp_i ),
    .op_valid_o  ( op_valid  ),
    .op_o        ( op        ),
    .acc_valid_i ( acc_valid ),
    .acc_i       ( acc       ),
    .busy_o      ( busy      ),
    .done_o      ( done      ),
    .sum_o       ( sum       )
  );

  // Start pulse doubles as accumulator clear
  acc_mac_engine #(
    .MacStages ( MacStages )
  ) u_mac_engine (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .en_i        ( en_q      ),
    .clear_i     ( start     ),
    .op_valid_i  ( op_valid  ),
    .op_i        ( op        ),
    .acc_valid_o ( acc_valid ),
    .acc_o       ( acc       )
  );

  assign busy_o = busy;

endmodule

// ==== dv/tb_mem_model.sv ====
/*
 * Behavioral shared memory with request/grant timing and 0 to 3 cycle grant delay.
 * Word addressed, 4 KiB by default; higher address bits alias.
 * Counts granted writes and any request seen while the DUT enable is low.
 */

`timescale 1ns/10ps

module tb_mem_model #(
  parameter int unsigned Words = 1024
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          en_i,  // Registered enable as the DUT sees it
  input  acc_pkg::mem_req_t             mem_req_i,
  output acc_pkg::mem_rsp_t             mem_rsp_o,
  input  logic                          load_en_i,
  input  logic [acc_pkg::AddrWidth-1:0] load_addr_i,
  input  logic [acc_pkg::DataWidth-1:0] load_data_i,
  output int unsigned                   wr_cnt_o,
  output int unsigned                   frozen_req_cnt_o
);
  import acc_pkg::*;

  localparam int unsigned IdxWidth = $clog2(Words);

  logic [DataWidth-1:0] mem [Words];
  logic [1:0]           delay_q;  // Cycles left before the next grant
  logic                 rvalid_q;
  logic [DataWidth-1:0] rdata_q;
  logic [IdxWidth-1:0]  req_idx;

  assign req_idx          = mem_req_i.addr[IdxWidth+1:2];
  assign mem_rsp_o.gnt    = mem_req_i.req & (delay_q == 2'd0);
  assign mem_rsp_o.rvalid = rvalid_q;
  assign mem_rsp_o.rdata  = rdata_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delay_q          <= 2'd0;
      rvalid_q         <= 1'b0;
      rdata_q          <= '0;
      wr_cnt_o         <= 0;
      frozen_req_cnt_o <= 0;
      for (int unsigned i = 0; i < Words; i++) begin
        mem[i] <= 32'hC0DE_0000 ^ (i << 2);  // Fill tied to the byte address
      end
    end else begin
      rvalid_q <= 1'b0;
      if (mem_req_i.req && mem_rsp_o.gnt) begin
        delay_q <= 2'($urandom % 4);  // Delay for the next request
        if (mem_req_i.we) begin
          mem[req_idx] <= mem_req_i.wdata;
          wr_cnt_o     <= wr_cnt_o + 1;
        end else begin
          rvalid_q <= 1'b1;
          rdata_q  <= mem[req_idx];
        end
      end else if (mem_req_i.req) begin
        delay_q <= delay_q - 2'd1;
      end
      if (mem_req_i.req && !en_i) frozen_req_cnt_o <= frozen_req_cnt_o + 1;
      // Backdoor load from the testbench
      if (load_en_i) mem[load_addr_i[IdxWidth+1:2]] <= load_data_i;
    end
  end

endmodule

// ==== dv/tb_acc_complex.sv ====
/*
 * Testbench of the accelerator complex acting as the AXI4-Lite host.
 * Vectors sit at fixed bases and hold at most 64 elements; MacStages is 3 here.
 */

`timescale 1ns/10ps

module tb_acc_complex;
  import acc_pkg::*;

  localparam int unsigned MacStages      = 3;
  localparam int unsigned ResetCycles    = 10;
  localparam int unsigned JobCount       = 7;
  localparam int unsigned JobCycles      = 400;
  localparam int unsigned WatchdogCycles = (JobCount + 2) * JobCycles + ResetCycles;
  localparam logic [31:0] ABase          = 32'h0000_0100;
  localparam logic [31:0] BBase          = 32'h0000_0200;
  localparam logic [31:0] DstBase        = 32'h0000_0300;

  typedef struct packed {
    logic [15:0] len;
    logic [15:0] a_seed;  // 0 gives random elements, else a constant element
    logic [15:0] b_seed;
    logic        toggle_en;
    logic        busy_start;
  } job_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        enable;
  logic        enable_q;  // Mirrors the DUT's registered enable
  logic        irq;
  logic        busy;
  logic        load_en;
  logic [31:0] load_addr;
  logic [31:0] load_data;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  int unsigned wr_cnt;
  int unsigned frozen_cnt;
  int unsigned ready_frozen_cnt = 0;
  int unsigned err_cnt = 0;
  int unsigned test_cnt = 0;
  int unsigned fail_cnt = 0;
  job_t        jobs [JobCount];
  logic [31:0] a_words [64];
  logic [31:0] b_words [64];

  always #20 clk = ~clk;

  acc_complex #(
    .MacStages ( MacStages )
  ) u_dut (
    .clk_i      ( clk      ),
    .rst_ni     ( rst_n    ),
    .enable_i   ( enable   ),
    .axil_req_i ( axil_req ),
    .axil_rsp_o ( axil_rsp ),
    .mem_req_o  ( mem_req  ),
    .mem_rsp_i  ( mem_rsp  ),
    .irq_o      ( irq      ),
    .busy_o     ( busy     )
  );

  tb_mem_model u_mem (
    .clk_i            ( clk        ),
    .rst_ni           ( rst_n      ),
    .en_i             ( enable_q   ),
    .mem_req_i        ( mem_req    ),
    .mem_rsp_o        ( mem_rsp    ),
    .load_en_i        ( load_en    ),
    .load_addr_i      ( load_addr  ),
    .load_data_i      ( load_data  ),
    .wr_cnt_o         ( wr_cnt     ),
    .frozen_req_cnt_o ( frozen_cnt )
  );

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) enable_q <= 1'b0;
    else        enable_q <= enable;
  end

  // Any AXI ready while frozen is a failure
  always @(posedge clk) begin
    if (rst_n && !enable_q && (axil_rsp.aw_ready || axil_rsp.w_ready || axil_rsp.ar_ready)) begin
      ready_frozen_cnt++;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int unsigned err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("%s: passed", name);
    end else begin
      fail_cnt++;
      $display("%s: failed", name);
    end
  endtask

  task automatic write_reg(input logic [RegOffWidth-1:0] off, input logic [31:0] data,
                           output logic [1:0] resp);
    @(posedge clk);
    axil_req.aw_addr  <= AddrWidth'(off);
    axil_req.aw_valid <= 1'b1;
    axil_req.w_data   <= data;
    axil_req.w_strb   <= '1;
    axil_req.w_valid  <= 1'b1;
    axil_req.b_ready  <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.aw_ready) @(negedge clk);
    @(posedge clk);
    axil_req.aw_valid <= 1'b0;
    axil_req.w_valid  <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.b_valid) @(negedge clk);
    resp = axil_rsp.b_resp;
    @(posedge clk);
    axil_req.b_ready <= 1'b0;
  endtask

  task automatic read_reg(input logic [RegOffWidth-1:0] off, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge clk);
    axil_req.ar_addr  <= AddrWidth'(off);
    axil_req.ar_valid <= 1'b1;
    axil_req.r_ready  <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.ar_ready) @(negedge clk);
    @(posedge clk);
    axil_req.ar_valid <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.r_valid) @(negedge clk);
    data = axil_rsp.r_data;
    resp = axil_rsp.r_resp;
    @(posedge clk);
    axil_req.r_ready <= 1'b0;
  endtask

  task automatic write_checked(input logic [RegOffWidth-1:0] off, input logic [31:0] data,
                               input string what);
    logic [1:0] resp;
    write_reg(off, data, resp);
    check_value({what, " write response"}, 32'(resp), 32'(RespOkay));
  endtask

  task automatic read_checked(input logic [RegOffWidth-1:0] off, input logic [31:0] exp,
                              input string what);
    logic [31:0] data;
    logic [1:0]  resp;
    read_reg(off, data, resp);
    check_value({what, " read data"}, data, exp);
    check_value({what, " read response"}, 32'(resp), 32'(RespOkay));
  endtask

  task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    load_en   <= 1'b1;
    load_addr <= addr;
    load_data <= data;
  endtask

  function automatic logic [15:0] elem_value(input logic [15:0] seed);
    if (seed == 16'h0) return 16'($urandom);
    return seed;
  endfunction

  // Signed 16-bit elements, sum wraps at 32 bits
  function automatic logic [31:0] dot_product(input int unsigned n);
    logic [31:0] acc;
    int          prod;
    acc = '0;
    for (int unsigned i = 0; i < n; i++) begin
      prod = int'($signed(a_words[i][15:0])) * int'($signed(b_words[i][15:0]));
      acc  = acc + 32'(prod);
    end
    return acc;
  endfunction

  task automatic test_registers();
    int unsigned err_before;
    err_before = err_cnt;
    check_value("irq after reset", 32'(irq), 32'h0);
    read_checked(RegStatus, 32'h0, "status after reset");
    write_checked(RegAAddr, 32'h0000_1234, "A address");
    write_checked(RegBAddr, 32'hABCD_0040, "B address");
    write_checked(RegDstAddr, 32'h8000_0FFC, "dst address");
    write_checked(RegLen, 32'h0000_BEEF, "length");
    read_checked(RegAAddr, 32'h0000_1234, "A address");
    read_checked(RegBAddr, 32'hABCD_0040, "B address");
    read_checked(RegDstAddr, 32'h8000_0FFC, "dst address");
    read_checked(RegLen, 32'h0000_BEEF, "length");
    report_test("register readback", err_before);
  endtask

  task automatic test_unmapped();
    int unsigned err_before;
    logic [31:0] data;
    logic [1:0]  resp;
    err_before = err_cnt;
    write_reg(5'h1C, 32'hFFFF_FFFF, resp);
    check_value("unmapped write response", 32'(resp), 32'(RespSlvErr));
    read_reg(5'h1C, data, resp);
    check_value("unmapped read response", 32'(resp), 32'(RespSlvErr));
    check_value("unmapped read data", data, 32'h0);
    report_test("unmapped offset", err_before);
  endtask

  task automatic run_job(input int unsigned j);
    job_t        job;
    int unsigned err_before;
    int unsigned wr_before;
    int unsigned frozen_before;
    int unsigned ready_before;
    int unsigned waited;
    logic [31:0] dst;
    logic [31:0] expected;
    job           = jobs[j];
    err_before    = err_cnt;
    dst           = DstBase + 32'(j * 4);
    for (int unsigned i = 0; i < 32'(job.len); i++) begin
      a_words[i] = {16'($urandom), elem_value(job.a_seed)};  // Junk upper half
      b_words[i] = {16'($urandom), elem_value(job.b_seed)};
      load_word(ABase + 32'(i * 4), a_words[i]);
      load_word(BBase + 32'(i * 4), b_words[i]);
    end
    @(posedge clk);
    load_en <= 1'b0;
    expected      = dot_product(32'(job.len));
    wr_before     = wr_cnt;
    frozen_before = frozen_cnt;
    ready_before  = ready_frozen_cnt;

    write_checked(RegAAddr, ABase, "A address");
    write_checked(RegBAddr, BBase, "B address");
    write_checked(RegDstAddr, dst, "dst address");
    write_checked(RegLen, 32'(job.len), "length");
    write_checked(RegCtrl, 32'h1, "start");
    if (job.busy_start) begin
      @(negedge clk);
      while (!busy) @(negedge clk);
      write_checked(RegCtrl, 32'h1, "start while busy");
    end
    if (job.toggle_en) begin
      repeat (8) @(posedge clk);
      // Freeze while a read still waits two or more cycles for its grant
      @(negedge clk);
      while (!(mem_req.req && u_mem.delay_q >= 2'd2)) @(negedge clk);
      @(posedge clk);
      enable <= 1'b0;
      repeat (30) @(posedge clk);
      @(negedge clk);
      check_value("busy while frozen", 32'(busy), 32'h1);
      @(posedge clk);
      enable <= 1'b1;
    end

    waited = 0;
    @(negedge clk);
    while (!irq && waited < JobCycles) begin
      @(negedge clk);
      waited++;
    end
    if (!irq) begin
      $display("job %0d: no interrupt within %0d cycles", j, JobCycles);
      err_cnt++;
    end
    check_value("sum in memory", u_mem.mem[dst[11:2]], expected);
    read_checked(RegResult, expected, "result");
    read_checked(RegStatus, 32'h2, "status after job");
    check_value("result writes", wr_cnt - wr_before, 32'd1);
    check_value("requests while frozen", frozen_cnt - frozen_before, 32'd0);
    check_value("AXI ready while frozen", ready_frozen_cnt - ready_before, 32'd0);

    // Clearing done drops irq
    write_checked(RegStatus, 32'h2, "done clear");
    @(negedge clk);
    check_value("irq after clear", 32'(irq), 32'h0);
    read_checked(RegStatus, 32'h0, "status after clear");
    report_test($sformatf("job %0d len %0d", j, job.len), err_before);
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: the run did not end within %0d cycles", WatchdogCycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    void'($urandom(35));
    rst_n     = 1'b0;
    enable    = 1'b1;
    axil_req  = '0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    //                len     a_seed    b_seed  toggle busy_start
    jobs[0] = '{16'd0,  16'h0000, 16'h0000, 1'b0, 1'b0};
    jobs[1] = '{16'd1,  16'h0003, 16'hFFFB, 1'b0, 1'b0};
    jobs[2] = '{16'd5,  16'h0000, 16'h0000, 1'b0, 1'b0};
    jobs[3] = '{16'd7,  16'h8000, 16'h8000, 1'b0, 1'b0};  // Wraps past 2^32
    jobs[4] = '{16'd6,  16'h7FFF, 16'h8000, 1'b0, 1'b0};
    jobs[5] = '{16'd12, 16'h0000, 16'h0000, 1'b1, 1'b0};
    jobs[6] = '{16'd10, 16'h0000, 16'h0000, 1'b0, 1'b1};

    repeat (ResetCycles - 1) @(posedge clk);
    @(negedge clk);
    check_value("mem req in reset", 32'(mem_req.req), 32'h0);
    check_value("busy in reset", 32'(busy), 32'h0);
    check_value("irq in reset", 32'(irq), 32'h0);
    check_value("AXI valid in reset", 32'({axil_rsp.b_valid, axil_rsp.r_valid}), 32'h0);
    check_value("AXI ready in reset",
                32'({axil_rsp.aw_ready, axil_rsp.w_ready, axil_rsp.ar_ready}), 32'h0);
    report_test("reset state", 0);
    @(posedge clk);
    rst_n <= 1'b1;

    test_registers();
    test_unmapped();
    for (int unsigned j = 0; j < JobCount; j++) begin
      run_job(j);
    end

    $display("%0d tests run, %0d failed, %0d check errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
design/acc_pkg.sv
design/acc_regfile.sv
design/acc_streamer.sv
design/acc_mac_engine.sv
design/acc_complex.sv
dv/tb_mem_model.sv
dv/tb_acc_complex.sv

// ==== Makefile ====
TOP := tb_acc_complex
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench, log in $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
